// ==== bench/tile_tb_tasks.svh ====
`ifndef TILE_TB_TASKS_SVH
`define TILE_TB_TASKS_SVH

//////////////////////////////
// Random numbers
//////////////////////////////

// One LCG step, full 32-bit period
function automatic logic [31:0] lcg_step(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// Next operand from the stimulus stream
function automatic tile_pkg::word_t rand_word();
   stim_seed = lcg_step(stim_seed);
   return stim_seed;
endfunction

//////////////////////////////
// RV32 encoders
//////////////////////////////

localparam tile_pkg::instr_t ECALL_INSTR = {25'b0, `TILE_OP_SYSTEM};

function automatic tile_pkg::instr_t addi_instr(input tile_pkg::reg_addr_t rd,
                                                input tile_pkg::reg_addr_t rs1,
                                                input logic [11:0] imm);
   return {imm, rs1, 3'b000, rd, `TILE_OP_OP_IMM};
endfunction

function automatic tile_pkg::instr_t lui_instr(input tile_pkg::reg_addr_t rd,
                                               input logic [19:0] imm);
   return {imm, rd, `TILE_OP_LUI};
endfunction

// R-type, funct7 picks SUB or MUL
function automatic tile_pkg::instr_t rtype_instr(input logic [6:0] funct7,
                                                 input logic [2:0] funct3,
                                                 input tile_pkg::reg_addr_t rd,
                                                 input tile_pkg::reg_addr_t rs1,
                                                 input tile_pkg::reg_addr_t rs2);
   return {funct7, rs2, rs1, funct3, rd, `TILE_OP_OP};
endfunction

// S-type, funct3 0 is SB and 2 is SW
function automatic tile_pkg::instr_t store_instr(input logic [2:0] funct3,
                                                 input tile_pkg::reg_addr_t rs2,
                                                 input tile_pkg::reg_addr_t base,
                                                 input logic [11:0] offset);
   return {offset[11:5], rs2, base, funct3, offset[4:0], `TILE_OP_STORE};
endfunction

//////////////////////////////
// Ring packets
//////////////////////////////

// Packet is a single-cycle strobe, then the ring goes quiet for a cycle
task automatic send_packet(input tile_pkg::net_op_e op, input tile_pkg::word_t addr,
                           input tile_pkg::word_t data, input tile_pkg::ring_id_t id,
                           input logic bc, input logic ext);
   @(posedge clk);
   net_packet <= '{valid: 1'b1, external: ext, bc: bc, ring_id: id, net_op: op,
                   addr: addr, data: data};
   @(posedge clk);
   net_packet <= '0;
endtask

// Register preset addressed to this tile
task automatic write_reg(input tile_pkg::reg_addr_t idx, input tile_pkg::word_t value);
   send_packet(tile_pkg::NET_REG, {27'b0, idx}, value, `TILE_RING_ID, 1'b0, 1'b0);
endtask

// Word k of the program goes to byte address (base + k) * 4
task automatic load_program(input tile_pkg::imem_addr_t base);
   tile_pkg::imem_addr_t waddr;
   foreach (prog_q[i])
   begin
      waddr = base + tile_pkg::imem_addr_t'(i);
      send_packet(tile_pkg::NET_INSTR, {22'b0, waddr, 2'b00}, prog_q[i],
                  `TILE_RING_ID, 1'b0, 1'b0);
   end
endtask

`endif

// ==== bench/tile_tb.sv ====
`default_nettype none

`include "tile_consts.svh"

module tile_tb;

   timeunit 1ns;
   timeprecision 1ps;

   // Cycle budget from packet count, instruction count, stores and the one MUL
   localparam int NUM_PACKETS = 46;
   localparam int NUM_INSTRS  = 30;
   localparam int NUM_STORES  = 16;
   localparam int NUM_PROGS   = 4;
   localparam int TIMEOUT_CYCLES = 8 + 2 * NUM_PACKETS + 3 * NUM_INSTRS + 6 * NUM_STORES
                                 + (`TILE_MUL_CYCLES + 2) + 8 * NUM_PROGS + 100;

   logic                  clk;
   logic                  reset;
   tile_pkg::net_packet_s net_packet;
   logic                  mem_yumi;
   tile_pkg::mem_req_s    to_mem;
   tile_pkg::debug_s      debug;

   int unsigned value_errors;
   int unsigned protocol_errors;
   int unsigned stores_checked;
   int unsigned cycle_count;
   logic        started;
   logic [31:0] stim_seed;
   logic [31:0] mem_seed;
   logic [1:0]  wait_left;
   logic        req_seen;

   // Expected stores in issue order, each tagged with its test
   tile_pkg::mem_req_s exp_q[$];
   string              name_q[$];
   tile_pkg::instr_t   prog_q[$];

   `include "tile_tb_tasks.svh"

   tile_core uut
      (.clk(clk), .reset(reset), .net_packet_i(net_packet), .mem_yumi_i(mem_yumi),
       .to_mem_o(to_mem), .debug_o(debug));

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // Data memory model
   //////////////////////////////

   // Yumi follows a new request after 0 to 3 extra cycles
   always @(posedge clk)
   begin
      if (reset)
      begin
         mem_yumi <= 1'b0;
         req_seen = 1'b0;
         wait_left = '0;
      end
      else if (to_mem.valid && mem_yumi)
      begin
         check_store(to_mem);
         mem_yumi <= 1'b0;
         req_seen = 1'b0;
      end
      else if (to_mem.valid)
      begin
         if (!req_seen)
         begin
            mem_seed = lcg_step(mem_seed);
            wait_left = mem_seed[17:16];
            req_seen = 1'b1;
         end
         if (wait_left == 2'd0)
            mem_yumi <= 1'b1;
         else
            wait_left = wait_left - 2'd1;
      end
   end

   // Scoreboard, accepted store against the oldest expected one
   task automatic check_store(input tile_pkg::mem_req_s act);
      tile_pkg::mem_req_s exp;
      string              name;
      assert (exp_q.size() > 0)
      else
      begin
         protocol_errors++;
         $display("Store to address %h arrived with no store expected", act.addr);
      end
      if (exp_q.size() > 0)
      begin
         exp  = exp_q.pop_front();
         name = name_q.pop_front();
         stores_checked++;
         assert (act.wen == exp.wen)
         else
         begin
            value_errors++;
            $display("ERROR %s: wen expected %b actual %b", name, exp.wen, act.wen);
         end
         assert (act.addr == exp.addr)
         else
         begin
            value_errors++;
            $display("ERROR %s: addr expected %h actual %h", name, exp.addr, act.addr);
         end
         assert (act.write_data == exp.write_data)
         else
         begin
            value_errors++;
            $display("ERROR %s: data expected %h actual %h", name, exp.write_data,
                     act.write_data);
         end
         assert (act.mask == exp.mask)
         else
         begin
            value_errors++;
            $display("ERROR %s: mask expected %b actual %b", name, exp.mask, act.mask);
         end
      end
   endtask

   task automatic expect_store(input string name, input tile_pkg::word_t addr,
                               input tile_pkg::word_t data, input tile_pkg::byte_mask_t mask);
      exp_q.push_back('{valid: 1'b1, wen: 1'b1, mask: mask, addr: addr, write_data: data});
      name_q.push_back(name);
   endtask

   // Load, start with a PC write, then wait out the run until ECALL
   task automatic run_program(input tile_pkg::imem_addr_t base);
      load_program(base);
      started <= 1'b1;
      send_packet(tile_pkg::NET_PC, {22'b0, base, 2'b00}, '0, `TILE_RING_ID, 1'b0, 1'b0);
      while (debug.state == tile_pkg::IDLE)
         @(negedge clk);
      while (debug.state != tile_pkg::IDLE)
         @(negedge clk);
      // Quiet cycles, any stray store trips the idle check
      repeat (4) @(posedge clk);
      assert (exp_q.size() == 0)
      else
      begin
         protocol_errors++;
         $display("%0d expected stores were never issued", exp_q.size());
         exp_q.delete();
         name_q.delete();
      end
   endtask

   //////////////////////////////
   // Protocol checks
   //////////////////////////////

   // Pending request frozen until the memory takes it
   assert property (@(posedge clk) disable iff (reset)
      (to_mem.valid && !mem_yumi) |=> $stable(to_mem))
   else
   begin
      protocol_errors++;
      $display("Store request changed while yumi was low");
   end

   // An idle core has no store in flight, after reset or after ECALL
   assert property (@(posedge clk) disable iff (reset)
      (debug.state == tile_pkg::IDLE) |-> !to_mem.valid)
   else
   begin
      protocol_errors++;
      $display("Store request raised while the core was idle");
   end

   assert property (@(posedge clk) disable iff (reset)
      !started |-> (debug.state == tile_pkg::IDLE))
   else
   begin
      protocol_errors++;
      $display("Core left IDLE before any PC write was sent");
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, core still running after %0d cycles", cycle_count);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial
   begin
      tile_pkg::word_t a;
      tile_pkg::word_t b;
      tile_pkg::word_t r;
      logic [11:0]     imm12;
      logic [19:0]     imm20;
      int              k;
      reset = 1'b1;
      net_packet = '0;
      mem_yumi = 1'b0;
      started = 1'b0;
      value_errors = 0;
      protocol_errors = 0;
      stores_checked = 0;
      cycle_count = 0;
      stim_seed = 32'h9961;
      mem_seed = 32'h9961;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      assert (debug.state == tile_pkg::IDLE && !to_mem.valid && debug.pc == '0)
      else
      begin
         protocol_errors++;
         $display("Core not idle at PC 0 with no store after reset");
      end

      // ALU ops on preset registers, every result stored with SW
      a = rand_word();
      b = rand_word();
      r = rand_word();
      imm12 = r[11:0];
      imm20 = r[31:12];
      write_reg(5'd1, a);
      write_reg(5'd2, b);
      prog_q.delete();
      prog_q.push_back(rtype_instr(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
      prog_q.push_back(rtype_instr(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
      prog_q.push_back(rtype_instr(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2));
      prog_q.push_back(rtype_instr(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2));
      prog_q.push_back(rtype_instr(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2));
      prog_q.push_back(addi_instr(5'd8, 5'd1, imm12));
      prog_q.push_back(lui_instr(5'd9, imm20));
      // Write to x0 is dropped
      prog_q.push_back(addi_instr(5'd0, 5'd1, 12'h05a));
      for (k = 0; k < 8; k++)
         prog_q.push_back(store_instr(3'b010, (k == 7) ? 5'd0 : 5'(3 + k), 5'd0,
                                      12'(32'h100 + 4 * k)));
      prog_q.push_back(ECALL_INSTR);
      // Store behind ECALL, the halted core never issues it
      prog_q.push_back(store_instr(3'b010, 5'd1, 5'd0, 12'h120));
      expect_store("add", 32'h100, a + b, 4'b1111);
      expect_store("sub", 32'h104, a - b, 4'b1111);
      expect_store("and", 32'h108, a & b, 4'b1111);
      expect_store("or", 32'h10c, a | b, 4'b1111);
      expect_store("xor", 32'h110, a ^ b, 4'b1111);
      expect_store("addi", 32'h114, a + {{20{imm12[11]}}, imm12}, 4'b1111);
      expect_store("lui", 32'h118, {imm20, 12'h000}, 4'b1111);
      expect_store("x0_write", 32'h11c, 32'h0, 4'b1111);
      run_program(8'd0);

      // MUL keeps the low word of the product
      a = rand_word();
      b = rand_word();
      write_reg(5'd1, a);
      write_reg(5'd2, b);
      prog_q.delete();
      prog_q.push_back(rtype_instr(`TILE_FUNCT7_MUL, 3'b000, 5'd3, 5'd1, 5'd2));
      prog_q.push_back(store_instr(3'b010, 5'd3, 5'd0, 12'h200));
      prog_q.push_back(ECALL_INSTR);
      expect_store("mul", 32'h200, a * b, 4'b1111);
      run_program(8'd32);

      // SB to every byte offset of one word
      a = rand_word();
      write_reg(5'd1, a);
      write_reg(5'd2, 32'h300);
      prog_q.delete();
      for (k = 0; k < 4; k++)
      begin
         prog_q.push_back(store_instr(3'b000, 5'd1, 5'd2, 12'(k)));
         expect_store($sformatf("sb_offset%0d", k), 32'h300 + k,
                      {24'b0, a[7:0]} << (8 * k), 4'b0001 << k);
      end
      prog_q.push_back(ECALL_INSTR);
      run_program(8'd64);

      // Packet filter, foreign unicast and external dropped, foreign broadcast taken
      a = rand_word();
      b = rand_word();
      r = rand_word();
      write_reg(5'd1, a);
      send_packet(tile_pkg::NET_REG, 32'd1, ~a, 4'd5, 1'b0, 1'b0);
      write_reg(5'd2, b);
      send_packet(tile_pkg::NET_REG, 32'd2, ~b, `TILE_RING_ID, 1'b0, 1'b1);
      write_reg(5'd3, ~r);
      send_packet(tile_pkg::NET_REG, 32'd3, r, 4'd9, 1'b1, 1'b0);
      prog_q.delete();
      prog_q.push_back(store_instr(3'b010, 5'd1, 5'd0, 12'h400));
      prog_q.push_back(store_instr(3'b010, 5'd2, 5'd0, 12'h404));
      prog_q.push_back(store_instr(3'b010, 5'd3, 5'd0, 12'h408));
      prog_q.push_back(ECALL_INSTR);
      expect_store("foreign_id", 32'h400, a, 4'b1111);
      expect_store("external", 32'h404, b, 4'b1111);
      expect_store("broadcast", 32'h408, r, 4'b1111);
      run_program(8'd96);

      $display("Stores checked %0d, value errors %0d, protocol errors %0d",
               stores_checked, value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== common/tile_consts.svh ====
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Data word and register index
`define TILE_XLEN        32
`define TILE_REG_AW      5

// Instruction memory is word addressed
`define TILE_IMEM_AW     8

// Memory depths
`define TILE_IMEM_DEPTH  256
`define TILE_REG_NUM     32

//////////////////////////////
// Ring network
//////////////////////////////

`define TILE_RING_ID_W   4
// ID of this tile on the ring
`define TILE_RING_ID     4'd3

// Iterations of the shift-add multiplier, one per multiplier bit
`define TILE_MUL_CYCLES  32

//////////////////////////////
// RV32 major opcodes
//////////////////////////////

`define TILE_OP_OP_IMM   7'b0010011
`define TILE_OP_LUI      7'b0110111
`define TILE_OP_OP       7'b0110011
`define TILE_OP_STORE    7'b0100011
`define TILE_OP_SYSTEM   7'b1110011

// funct7 of the M extension
`define TILE_FUNCT7_MUL  7'b0000001

`endif

// ==== common/tile_pkg.sv ====
`default_nettype none

`include "tile_consts.svh"

package tile_pkg;

   //////////////////////////////
   // Vector types
   //////////////////////////////

   typedef logic [`TILE_XLEN-1:0]      word_t;
   typedef logic [`TILE_REG_AW-1:0]    reg_addr_t;
   typedef logic [`TILE_IMEM_AW-1:0]   imem_addr_t;
   typedef logic [`TILE_RING_ID_W-1:0] ring_id_t;
   // One bit per byte lane of a store
   typedef logic [3:0]                 byte_mask_t;
   typedef logic [31:0]                instr_t;

   // Command carried by a ring packet
   typedef enum logic [1:0] {
      NET_NONE,
      NET_PC,
      NET_INSTR,
      NET_REG
   } net_op_e;

   // Sequencer states
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      EXEC,
      MUL_WAIT,
      STORE_WAIT
   } core_state_e;

   //////////////////////////////
   // Structs
   //////////////////////////////

   // Ring packet as seen by the tile
   typedef struct packed {
      logic     valid;
      logic     external;
      logic     bc;
      ring_id_t ring_id;
      net_op_e  net_op;
      // Byte address, register index sits in the low bits
      word_t    addr;
      word_t    data;
   } net_packet_s;

   // Request to data memory
   typedef struct packed {
      logic       valid;
      logic       wen;
      byte_mask_t mask;
      word_t      addr;
      word_t      write_data;
   } mem_req_s;

   typedef struct packed {
      imem_addr_t  pc;
      core_state_e state;
   } debug_s;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

`include "tile_consts.svh"

module alu
   (
   input  tile_pkg::instr_t     instr_i,
   input  tile_pkg::word_t      rs1_i,
   input  tile_pkg::word_t      rs2_i,
   output tile_pkg::word_t      result_o,
   output tile_pkg::word_t      store_data_o,
   output tile_pkg::byte_mask_t store_mask_o,
   output tile_pkg::word_t      store_addr_o
   );

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   tile_pkg::word_t imm_i;
   tile_pkg::word_t imm_s;

   // Instruction fields
   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // Sign extended I and S immediates
   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

   //////////////////////////////
   // Arithmetic and logic
   //////////////////////////////

   always_comb
   begin
      result_o = '0;
      case (opcode)
         `TILE_OP_OP_IMM: result_o = rs1_i + imm_i;
         // Upper immediate, low 12 bits cleared
         `TILE_OP_LUI:    result_o = {instr_i[31:12], 12'b0};
         `TILE_OP_OP:
         begin
            case (funct3)
               // funct7 bit 5 selects SUB
               3'b000:  result_o = funct7[5] ? (rs1_i - rs2_i) : (rs1_i + rs2_i);
               3'b100:  result_o = rs1_i ^ rs2_i;
               3'b110:  result_o = rs1_i | rs2_i;
               3'b111:  result_o = rs1_i & rs2_i;
               default: result_o = '0;
            endcase
         end
         default:         result_o = '0;
      endcase
   end

   //////////////////////////////
   // Store path
   //////////////////////////////

   // Byte address of the store
   assign store_addr_o = rs1_i + imm_s;

   always_comb
   begin
      if (funct3 == 3'b000)
      begin
         // SB moves the low byte into its lane
         store_data_o = {24'b0, rs2_i[7:0]} << {store_addr_o[1:0], 3'b000};
         store_mask_o = 4'b0001 << store_addr_o[1:0];
      end
      else
      begin
         // SW, full word
         store_data_o = rs2_i;
         store_mask_o = 4'b1111;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/core_fsm.sv ====
`default_nettype none

`include "tile_consts.svh"

module core_fsm
   (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    pc_cmd_i,
   input  tile_pkg::word_t        cmd_addr_i,
   input  tile_pkg::instr_t       instr_i,
   input  tile_pkg::word_t        alu_result_i,
   input  tile_pkg::word_t        mul_product_i,
   input  wire                    mul_done_i,
   input  wire                    mem_yumi_i,
   input  tile_pkg::word_t        store_data_i,
   input  tile_pkg::word_t        store_addr_i,
   input  tile_pkg::byte_mask_t   store_mask_i,
   output logic                   imem_re_o,
   output tile_pkg::imem_addr_t   pc_o,
   output logic                   rf_we_o,
   output tile_pkg::word_t        rf_wdata_o,
   output logic                   mul_start_o,
   output tile_pkg::mem_req_s     mem_req_o,
   output tile_pkg::core_state_e  state_o
   );

   tile_pkg::core_state_e state_r, state_n;
   tile_pkg::imem_addr_t  pc_r, pc_n;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_alu, is_mul, is_store, is_halt;
   logic       store_go;

   //////////////////////////////
   // Instruction class
   //////////////////////////////

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // ADDI, LUI and the R-type ADD SUB AND OR XOR
   assign is_alu = ((opcode == `TILE_OP_OP_IMM) & (funct3 == 3'b000))
                 | (opcode == `TILE_OP_LUI)
                 | ((opcode == `TILE_OP_OP) & (funct7 == 7'b0000000)
                    & (funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}))
                 | ((opcode == `TILE_OP_OP) & (funct7 == 7'b0100000) & (funct3 == 3'b000));
   assign is_mul   = (opcode == `TILE_OP_OP) & (funct7 == `TILE_FUNCT7_MUL) & (funct3 == 3'b000);
   // SB and SW
   assign is_store = (opcode == `TILE_OP_STORE) & ((funct3 == 3'b000) | (funct3 == 3'b010));
   // ECALL, all other fields zero
   assign is_halt  = (opcode == `TILE_OP_SYSTEM) & (instr_i[31:7] == '0);

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb
   begin
      state_n     = state_r;
      pc_n        = pc_r;
      imem_re_o   = 1'b0;
      rf_we_o     = 1'b0;
      rf_wdata_o  = alu_result_i;
      mul_start_o = 1'b0;
      store_go    = 1'b0;
      case (state_r)
         tile_pkg::IDLE:
         begin
            // PC write from the ring starts the core
            if (pc_cmd_i)
            begin
               pc_n    = cmd_addr_i[`TILE_IMEM_AW+1:2];
               state_n = tile_pkg::FETCH;
            end
         end
         tile_pkg::FETCH:
         begin
            imem_re_o = 1'b1;
            state_n   = tile_pkg::EXEC;
         end
         tile_pkg::EXEC:
         begin
            if (is_halt)
               state_n = tile_pkg::IDLE;
            else if (is_mul)
            begin
               mul_start_o = 1'b1;
               state_n     = tile_pkg::MUL_WAIT;
            end
            else if (is_store)
            begin
               store_go = 1'b1;
               state_n  = tile_pkg::STORE_WAIT;
            end
            else
            begin
               // Unknown opcodes fall through as no-ops
               rf_we_o = is_alu;
               pc_n    = pc_r + 1'b1;
               state_n = tile_pkg::FETCH;
            end
         end
         tile_pkg::MUL_WAIT:
         begin
            rf_wdata_o = mul_product_i;
            if (mul_done_i)
            begin
               rf_we_o = 1'b1;
               pc_n    = pc_r + 1'b1;
               state_n = tile_pkg::FETCH;
            end
         end
         tile_pkg::STORE_WAIT:
         begin
            // Leave once the memory takes the request
            if (mem_yumi_i)
            begin
               pc_n    = pc_r + 1'b1;
               state_n = tile_pkg::FETCH;
            end
         end
         default: state_n = tile_pkg::IDLE;
      endcase
   end

   //////////////////////////////
   // Registers
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_r         <= tile_pkg::IDLE;
         pc_r            <= '0;
         mem_req_o.valid <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         pc_r    <= pc_n;
         if (store_go)
            mem_req_o.valid <= 1'b1;
         else if (mem_yumi_i)
            mem_req_o.valid <= 1'b0;
      end
   end

   // Request payload captured on the way out of EXEC
   always_ff @(posedge clk)
   begin
      if (store_go)
      begin
         mem_req_o.wen        <= 1'b1;
         mem_req_o.mask       <= store_mask_i;
         mem_req_o.addr       <= store_addr_i;
         mem_req_o.write_data <= store_data_i;
      end
   end

   assign pc_o    = pc_r;
   assign state_o = state_r;

   // Pending request holds until yumi
   assert property (@(posedge clk) disable iff (reset)
      (mem_req_o.valid && !mem_yumi_i) |=> $stable(mem_req_o));

   // Multiplier answers only while the core waits for it
   assert property (@(posedge clk) disable iff (reset)
      mul_done_i |-> (state_r == tile_pkg::MUL_WAIT));

endmodule

`default_nettype wire

// ==== hdl/imem.sv ====
`default_nettype none

`include "tile_consts.svh"

module imem
   (
   input  wire                  clk,
   input  wire                  we_i,
   input  wire                  re_i,
   input  tile_pkg::imem_addr_t addr_i,
   input  tile_pkg::instr_t     wdata_i,
   output tile_pkg::instr_t     rdata_o
   );

   // Single port array, one instruction per word
   tile_pkg::instr_t mem [0:`TILE_IMEM_DEPTH-1];

   // Write wins over read on the shared port
   // Read data stays put when the port is idle, so the
   // executing instruction is held through long waits
   always_ff @(posedge clk)
   begin
      if (we_i)
      begin
         mem[addr_i] <= wdata_i;
      end
      else if (re_i)
      begin
         rdata_o <= mem[addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/net_cmd_decode.sv ====
`default_nettype none

`include "tile_consts.svh"

module net_cmd_decode
   (
   input  wire                 clk,
   input  wire                 reset,
   input  tile_pkg::net_packet_s net_packet_i,
   output logic                pc_cmd_o,
   output logic                instr_cmd_o,
   output logic                reg_cmd_o,
   output tile_pkg::word_t     cmd_addr_o,
   output tile_pkg::word_t     cmd_data_o
   );

   tile_pkg::net_packet_s packet_r;
   logic                  id_match;
   logic                  exec_packet;

   // Packet is held one cycle before it is decoded
   always_ff @(posedge clk)
   begin
      if (reset)
         packet_r <= '0;
      else
         packet_r <= net_packet_i;
   end

   // Our ID on a valid internal packet
   assign id_match = packet_r.valid & ~packet_r.external
                   & (packet_r.ring_id == `TILE_RING_ID);

   // Own ID and no broadcast, or a broadcast sent by another tile
   // A broadcast carrying our own ID came from this tile
   assign exec_packet = (id_match & ~packet_r.bc)
                      | (~id_match & packet_r.bc & packet_r.valid & ~packet_r.external);

   // One pulse per command type
   assign pc_cmd_o    = exec_packet & (packet_r.net_op == tile_pkg::NET_PC);
   assign instr_cmd_o = exec_packet & (packet_r.net_op == tile_pkg::NET_INSTR);
   assign reg_cmd_o   = exec_packet & (packet_r.net_op == tile_pkg::NET_REG);

   assign cmd_addr_o = packet_r.addr;
   assign cmd_data_o = packet_r.data;

   // Never more than one command per packet
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({pc_cmd_o, instr_cmd_o, reg_cmd_o}));

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

`include "tile_consts.svh"

module regfile
   (
   input  wire                 clk,
   input  wire                 we_i,
   input  tile_pkg::reg_addr_t waddr_i,
   input  tile_pkg::word_t     wdata_i,
   input  tile_pkg::reg_addr_t raddr1_i,
   input  tile_pkg::reg_addr_t raddr2_i,
   output tile_pkg::word_t     rdata1_o,
   output tile_pkg::word_t     rdata2_o
   );

   tile_pkg::word_t regs [0:`TILE_REG_NUM-1];

   // Single write port
   // x0 may be written, the read side hides it
   always_ff @(posedge clk)
   begin
      if (we_i)
      begin
         regs[waddr_i] <= wdata_i;
      end
   end

   //////////////////////////////
   // Read ports
   //////////////////////////////

   // Combinational reads, x0 is hardwired to zero
   assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
   assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== hdl/tile_core.sv ====
`default_nettype none

`include "tile_consts.svh"

module tile_core
   (
   input  wire                   clk,
   input  wire                   reset,
   input  tile_pkg::net_packet_s net_packet_i,
   input  wire                   mem_yumi_i,
   output tile_pkg::mem_req_s    to_mem_o,
   output tile_pkg::debug_s      debug_o
   );

   logic                  pc_cmd, instr_cmd, reg_cmd;
   tile_pkg::word_t       cmd_addr, cmd_data;
   tile_pkg::instr_t      instr;
   tile_pkg::imem_addr_t  pc, imem_addr;
   logic                  imem_re, imem_we, idle;
   logic                  core_rf_we, rf_we;
   tile_pkg::reg_addr_t   rf_waddr;
   tile_pkg::word_t       core_rf_wdata, rf_wdata;
   tile_pkg::word_t       rs1, rs2, alu_result, mul_product;
   tile_pkg::word_t       store_data, store_addr;
   tile_pkg::byte_mask_t  store_mask;
   logic                  mul_start, mul_done;
   tile_pkg::core_state_e state;

   net_cmd_decode u_net
      (.clk(clk), .reset(reset), .net_packet_i(net_packet_i),
       .pc_cmd_o(pc_cmd), .instr_cmd_o(instr_cmd), .reg_cmd_o(reg_cmd),
       .cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data));

   //////////////////////////////
   // Shared write ports
   //////////////////////////////

   // Ring writes land only while the core is idle
   assign idle      = (state == tile_pkg::IDLE);
   assign imem_we   = instr_cmd & idle;
   assign imem_addr = imem_we ? cmd_addr[`TILE_IMEM_AW+1:2] : pc;

   // Core write-back has the port while running
   assign rf_we    = core_rf_we | (reg_cmd & idle);
   assign rf_waddr = core_rf_we ? instr[11:7] : cmd_addr[`TILE_REG_AW-1:0];
   assign rf_wdata = core_rf_we ? core_rf_wdata : cmd_data;

   imem u_imem
      (.clk(clk), .we_i(imem_we), .re_i(imem_re), .addr_i(imem_addr),
       .wdata_i(cmd_data), .rdata_o(instr));

   regfile u_rf
      (.clk(clk), .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
       .raddr1_i(instr[19:15]), .raddr2_i(instr[24:20]),
       .rdata1_o(rs1), .rdata2_o(rs2));

   alu u_alu
      (.instr_i(instr), .rs1_i(rs1), .rs2_i(rs2), .result_o(alu_result),
       .store_data_o(store_data), .store_mask_o(store_mask),
       .store_addr_o(store_addr));

   // Busy only feeds the multiplier's own check
   mul_iterative u_mul
      (.clk(clk), .reset(reset), .start_i(mul_start), .a_i(rs1), .b_i(rs2),
       .busy_o(), .done_o(mul_done), .product_o(mul_product));

   core_fsm u_fsm
      (.clk(clk), .reset(reset), .pc_cmd_i(pc_cmd), .cmd_addr_i(cmd_addr),
       .instr_i(instr), .alu_result_i(alu_result), .mul_product_i(mul_product),
       .mul_done_i(mul_done), .mem_yumi_i(mem_yumi_i),
       .store_data_i(store_data), .store_addr_i(store_addr),
       .store_mask_i(store_mask), .imem_re_o(imem_re), .pc_o(pc),
       .rf_we_o(core_rf_we), .rf_wdata_o(core_rf_wdata),
       .mul_start_o(mul_start), .mem_req_o(to_mem_o), .state_o(state));

   assign debug_o = '{pc: pc, state: state};

endmodule

`default_nettype wire

// ==== mul/mul_iterative.sv ====
`default_nettype none

`include "tile_consts.svh"

module mul_iterative
   (
   input  wire             clk,
   input  wire             reset,
   input  wire             start_i,
   input  tile_pkg::word_t a_i,
   input  tile_pkg::word_t b_i,
   output logic            busy_o,
   output logic            done_o,
   output tile_pkg::word_t product_o
   );

   localparam int CNT_W = $clog2(`TILE_MUL_CYCLES);

   // Multiplicand shifts up, multiplier shifts down
   tile_pkg::word_t mcand_r;
   tile_pkg::word_t mplier_r;
   tile_pkg::word_t acc_r;
   logic [CNT_W-1:0] cnt_r;

   //////////////////////////////
   // Control
   //////////////////////////////

   // Start handles bit 0, the counter covers the remaining bits
   // Done rises in the cycle after the last add
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_o <= 1'b0;
         done_o <= 1'b0;
         cnt_r  <= '0;
      end
      else
      begin
         done_o <= 1'b0;
         if (start_i)
         begin
            busy_o <= 1'b1;
            cnt_r  <= CNT_W'(`TILE_MUL_CYCLES - 1);
         end
         else if (busy_o)
         begin
            cnt_r <= cnt_r - 1'b1;
            // Final bit
            if (cnt_r == CNT_W'(1))
            begin
               busy_o <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // Datapath
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (start_i)
      begin
         acc_r    <= b_i[0] ? a_i : '0;
         mcand_r  <= a_i << 1;
         mplier_r <= b_i >> 1;
      end
      else if (busy_o)
      begin
         // Add the shifted multiplicand when the multiplier bit is set
         acc_r    <= mplier_r[0] ? (acc_r + mcand_r) : acc_r;
         mcand_r  <= mcand_r << 1;
         mplier_r <= mplier_r >> 1;
      end
   end

   // Low word of the product, held until the next start
   assign product_o = acc_r;

   // Sequencer must wait for done before a new start
   assert property (@(posedge clk) disable iff (reset) start_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tile_tb

output=$(./obj_dir/Vtile_tb)
echo "$output"

# Exit status follows the pass line
echo "$output" | grep -qx "=== PASS ==="

// ==== verilog.f ====
+incdir+common
+incdir+bench
common/tile_pkg.sv
hdl/net_cmd_decode.sv
hdl/imem.sv
hdl/regfile.sv
hdl/alu.sv
mul/mul_iterative.sv
hdl/core_fsm.sv
hdl/tile_core.sv
bench/tile_tb.sv
